/* src/sd_spi_pkg.sv */
// Shared SD SPI-mode types and constants; frames go out MSB first and use fixed CRC bytes
`default_nettype none

package sd_spi_pkg;

  typedef logic [7:0] sd_byte_t;
  typedef logic [47:0] sd_frame_t; // Command, 32-bit argument, CRC
  typedef logic [31:0] sd_addr_t;

  // Byte-level jobs the sequencer hands to the transfer engine
  typedef enum logic [2:0] {
    OP_SEND_FRAME,
    OP_SEND_FILL,
    OP_SEND_DATA,
    OP_RECV_POLL,
    OP_RECV_DATA
  } xfer_op_t;

  localparam int FRAME_BYTES = 6;
  localparam sd_byte_t FILL_BYTE = 8'hFF;
  localparam int INIT_FILL_BYTES = 10; // Clocks for card power-up, CS high
  localparam int CRC_BYTES = 2;

  localparam sd_frame_t CMD0_FRAME = 48'h400000000095;
  localparam sd_frame_t CMD1_FRAME = 48'h4100000000F9;
  localparam sd_byte_t CMD16_INDEX = 8'h50; // SET_BLOCKLEN
  localparam sd_byte_t CMD17_INDEX = 8'h51; // READ_SINGLE_BLOCK
  localparam sd_byte_t CMD24_INDEX = 8'h58; // WRITE_BLOCK
  localparam sd_frame_t WRITE_TOKEN_FRAME = 48'hFFFFFFFFFFFE; // Gap bytes then start token

  localparam sd_byte_t R1_IDLE = 8'h01;
  localparam sd_byte_t R1_READY = 8'h00;
  localparam sd_byte_t TOKEN_START = 8'hFE;
  localparam sd_byte_t DATA_RESP_MASK = 8'h1F;
  localparam sd_byte_t DATA_ACCEPTED = 8'h05;

  localparam int BLOCK_LEN_DEFAULT = 512;

endpackage

`default_nettype wire

/* src/sd_cmd_shifter.sv */
// Six-byte command frame shifter; load and shift must not be asserted in the same cycle
`timescale 1ns/1ps
`default_nettype none

module sd_cmd_shifter (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  load,
  input  sd_spi_pkg::sd_frame_t frame,
  input  logic                  shift,
  output sd_spi_pkg::sd_byte_t  tx_byte,
  output logic                  last_byte
);

  localparam int FW = $bits(sd_spi_pkg::sd_frame_t);

  sd_spi_pkg::sd_frame_t frame_q;
  logic [2:0]            sent_cnt;

  // Frame contents, byte-wise shift toward the MSB
  always_ff @(posedge clk_i) begin
    if (load) begin
      frame_q <= frame;
    end else if (shift) begin
      frame_q <= {frame_q[FW-9:0], sd_spi_pkg::FILL_BYTE}; // Refill with idle bytes
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      sent_cnt <= '0;
    end else if (load) begin
      sent_cnt <= '0;
    end else if (shift) begin
      sent_cnt <= sent_cnt + 3'd1;
    end
  end

  assign tx_byte   = frame_q[FW-1 -: 8]; // Next byte on the wire
  assign last_byte = (sent_cnt == 3'(sd_spi_pkg::FRAME_BYTES - 1));

endmodule

`default_nettype wire

/* src/sd_xfer_engine.sv */
// Byte transfer engine, one SPI exchange in flight; BLOCK_LEN must be at least INIT_FILL_BYTES
`timescale 1ns/1ps
`default_nettype none

module sd_xfer_engine #(
  parameter int BLOCK_LEN = sd_spi_pkg::BLOCK_LEN_DEFAULT
) (
  input  logic                           clk_i,
  input  logic                           rst_i,
  input  logic                           op_start,
  input  sd_spi_pkg::xfer_op_t           op_kind,
  input  logic [$clog2(BLOCK_LEN+1)-1:0] op_count,
  input  sd_spi_pkg::sd_frame_t          op_frame,
  output logic                           op_done,
  output sd_spi_pkg::sd_byte_t           op_resp,
  output logic                           spi_start,
  output sd_spi_pkg::sd_byte_t           spi_tx_data,
  input  logic                           spi_done,
  input  sd_spi_pkg::sd_byte_t           spi_rx_data,
  input  sd_spi_pkg::sd_byte_t           wr_data,
  output logic                           wr_data_pop,
  output sd_spi_pkg::sd_byte_t           rd_data,
  output logic                           rd_data_valid
);

  localparam int CNT_W = $clog2(BLOCK_LEN + 1);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WAIT,
    ST_FINISH
  } state_t;

  state_t               state;
  sd_spi_pkg::xfer_op_t kind_q;
  logic [CNT_W-1:0]     count_q;
  logic [CNT_W-1:0]     byte_cnt;
  sd_spi_pkg::sd_byte_t rx_q;
  sd_spi_pkg::sd_byte_t frame_byte;
  logic                 frame_last;
  logic                 accept;
  logic                 byte_done;
  logic                 op_end;

  assign accept    = (state == ST_IDLE) && op_start;
  assign byte_done = (state == ST_WAIT) && spi_done;

  sd_cmd_shifter u_sd_cmd_shifter (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .load      (accept),
    .frame     (op_frame),
    .shift     (byte_done && (kind_q == sd_spi_pkg::OP_SEND_FRAME)),
    .tx_byte   (frame_byte),
    .last_byte (frame_last)
  );

  // Does the byte completing now end the operation
  always_comb begin
    case (kind_q)
      sd_spi_pkg::OP_SEND_FRAME: op_end = frame_last;
      sd_spi_pkg::OP_RECV_POLL:  op_end = (spi_rx_data != sd_spi_pkg::FILL_BYTE);
      default:                   op_end = ((byte_cnt + CNT_W'(1)) == count_q);
    endcase
  end

  always_comb begin
    case (kind_q)
      sd_spi_pkg::OP_SEND_FRAME: spi_tx_data = frame_byte;
      sd_spi_pkg::OP_SEND_DATA:  spi_tx_data = wr_data;
      default:                   spi_tx_data = sd_spi_pkg::FILL_BYTE; // Clock-out only
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state         <= ST_IDLE;
      kind_q        <= sd_spi_pkg::OP_SEND_FILL;
      byte_cnt      <= '0;
      spi_start     <= 1'b0;
      rd_data_valid <= 1'b0;
    end else begin
      spi_start     <= 1'b0;
      rd_data_valid <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (op_start) begin
            kind_q    <= op_kind;
            byte_cnt  <= '0;
            spi_start <= 1'b1; // First byte goes out next cycle
            state     <= ST_WAIT;
          end
        end
        ST_WAIT: begin
          if (spi_done) begin
            byte_cnt      <= byte_cnt + CNT_W'(1);
            rd_data_valid <= (kind_q == sd_spi_pkg::OP_RECV_DATA);
            if (op_end) begin
              state <= ST_FINISH;
            end else begin
              spi_start <= 1'b1; // Back-to-back bytes
            end
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      count_q <= op_count;
    end
    if (byte_done) begin
      rx_q <= spi_rx_data; // Latest card byte
    end
  end

  assign op_done     = (state == ST_FINISH);
  assign op_resp     = rx_q;
  assign rd_data     = rx_q;
  assign wr_data_pop = spi_start && (kind_q == sd_spi_pkg::OP_SEND_DATA);

endmodule

`default_nettype wire

/* src/sd_card_seq.sv */
// SD card sequencer; no timeouts or write-busy polling, and an error holds until reset
`timescale 1ns/1ps
`default_nettype none

module sd_card_seq #(
  parameter int BLOCK_LEN = sd_spi_pkg::BLOCK_LEN_DEFAULT
) (
  input  logic                           clk_i,
  input  logic                           rst_i,
  input  logic                           cmd_read,
  input  logic                           cmd_write,
  input  sd_spi_pkg::sd_addr_t           block_addr,
  output logic                           busy,
  output logic                           error,
  output logic                           card_cs,
  output logic                           op_start,
  output sd_spi_pkg::xfer_op_t           op_kind,
  output logic [$clog2(BLOCK_LEN+1)-1:0] op_count,
  output sd_spi_pkg::sd_frame_t          op_frame,
  input  logic                           op_done,
  input  sd_spi_pkg::sd_byte_t           op_resp
);

  localparam int CNT_W = $clog2(BLOCK_LEN + 1);
  localparam sd_spi_pkg::sd_addr_t BLK_ARG = BLOCK_LEN; // CMD16 argument

  typedef enum logic [4:0] {
    ST_BOOT, ST_INIT_FILL, ST_CMD0, ST_CMD0_RESP, ST_CMD1, ST_CMD1_RESP,
    ST_CMD16, ST_CMD16_RESP, ST_IDLE,
    ST_RD_CMD, ST_RD_RESP, ST_RD_TOKEN, ST_RD_DATA, ST_RD_CRC,
    ST_WR_CMD, ST_WR_RESP, ST_WR_TOKEN, ST_WR_DATA, ST_WR_CRC, ST_WR_DRESP,
    ST_ERROR
  } state_t;

  state_t               state;
  state_t               state_next;
  sd_spi_pkg::sd_addr_t addr_q;

  // Where to go once the current operation reports its last byte
  function automatic state_t after_op(input state_t st, input sd_spi_pkg::sd_byte_t resp);
    case (st)
      ST_INIT_FILL:  return ST_CMD0;
      ST_CMD0:       return ST_CMD0_RESP;
      ST_CMD0_RESP:  return (resp == sd_spi_pkg::R1_IDLE) ? ST_CMD1 : ST_ERROR;
      ST_CMD1:       return ST_CMD1_RESP;
      ST_CMD1_RESP:  return (resp == sd_spi_pkg::R1_IDLE)  ? ST_CMD1 :   // Still idle, resend
                            (resp == sd_spi_pkg::R1_READY) ? ST_CMD16 : ST_ERROR;
      ST_CMD16:      return ST_CMD16_RESP;
      ST_CMD16_RESP: return (resp == sd_spi_pkg::R1_READY) ? ST_IDLE : ST_ERROR;
      ST_RD_CMD:     return ST_RD_RESP;
      ST_RD_RESP:    return (resp == sd_spi_pkg::R1_READY) ? ST_RD_TOKEN : ST_ERROR;
      ST_RD_TOKEN:   return (resp == sd_spi_pkg::TOKEN_START) ? ST_RD_DATA : ST_ERROR;
      ST_RD_DATA:    return ST_RD_CRC;
      ST_RD_CRC:     return ST_IDLE;
      ST_WR_CMD:     return ST_WR_RESP;
      ST_WR_RESP:    return (resp == sd_spi_pkg::R1_READY) ? ST_WR_TOKEN : ST_ERROR;
      ST_WR_TOKEN:   return ST_WR_DATA;
      ST_WR_DATA:    return ST_WR_CRC;
      ST_WR_CRC:     return ST_WR_DRESP;
      ST_WR_DRESP:   return ((resp & sd_spi_pkg::DATA_RESP_MASK) == sd_spi_pkg::DATA_ACCEPTED)
                            ? ST_IDLE : ST_ERROR;
      default:       return ST_ERROR;
    endcase
  endfunction

  always_comb begin
    state_next = state;
    case (state)
      ST_BOOT:  state_next = ST_INIT_FILL;
      ST_IDLE: begin
        if (cmd_read) begin
          state_next = ST_RD_CMD; // Read has priority
        end else if (cmd_write) begin
          state_next = ST_WR_CMD;
        end
      end
      ST_ERROR: state_next = ST_ERROR;
      default: begin
        if (op_done) begin
          state_next = after_op(state, op_resp);
        end
      end
    endcase
  end

  // Operation parameters per state, sampled by the engine with op_start
  always_comb begin
    op_kind  = sd_spi_pkg::OP_RECV_POLL;
    op_count = '0;
    op_frame = {sd_spi_pkg::FRAME_BYTES{sd_spi_pkg::FILL_BYTE}};
    case (state)
      ST_INIT_FILL: begin
        op_kind  = sd_spi_pkg::OP_SEND_FILL;
        op_count = CNT_W'(sd_spi_pkg::INIT_FILL_BYTES);
      end
      ST_CMD0:  {op_kind, op_frame} = {sd_spi_pkg::OP_SEND_FRAME, sd_spi_pkg::CMD0_FRAME};
      ST_CMD1:  {op_kind, op_frame} = {sd_spi_pkg::OP_SEND_FRAME, sd_spi_pkg::CMD1_FRAME};
      ST_CMD16: begin
        op_kind  = sd_spi_pkg::OP_SEND_FRAME;
        op_frame = {sd_spi_pkg::CMD16_INDEX, BLK_ARG, sd_spi_pkg::FILL_BYTE};
      end
      ST_RD_CMD: begin
        op_kind  = sd_spi_pkg::OP_SEND_FRAME;
        op_frame = {sd_spi_pkg::CMD17_INDEX, addr_q, sd_spi_pkg::FILL_BYTE};
      end
      ST_WR_CMD: begin
        op_kind  = sd_spi_pkg::OP_SEND_FRAME;
        op_frame = {sd_spi_pkg::CMD24_INDEX, addr_q, sd_spi_pkg::FILL_BYTE};
      end
      ST_WR_TOKEN: begin
        op_kind  = sd_spi_pkg::OP_SEND_FRAME;
        op_frame = sd_spi_pkg::WRITE_TOKEN_FRAME;
      end
      ST_RD_DATA: {op_kind, op_count} = {sd_spi_pkg::OP_RECV_DATA, CNT_W'(BLOCK_LEN)};
      ST_WR_DATA: {op_kind, op_count} = {sd_spi_pkg::OP_SEND_DATA, CNT_W'(BLOCK_LEN)};
      ST_RD_CRC, ST_WR_CRC: begin
        op_kind  = sd_spi_pkg::OP_SEND_FILL; // CRC is not checked
        op_count = CNT_W'(sd_spi_pkg::CRC_BYTES);
      end
      default: op_kind = sd_spi_pkg::OP_RECV_POLL; // R1, token and data-response polls
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state    <= ST_BOOT;
      op_start <= 1'b0;
    end else begin
      state    <= state_next;
      op_start <= (state_next != state) && !(state_next inside {ST_IDLE, ST_ERROR});
    end
  end

  always_ff @(posedge clk_i) begin
    if ((state == ST_IDLE) && (cmd_read || cmd_write)) begin
      addr_q <= block_addr;
    end
  end

  assign busy    = (state != ST_IDLE);
  assign error   = (state == ST_ERROR);
  assign card_cs = state inside {ST_BOOT, ST_INIT_FILL, ST_IDLE, ST_ERROR}; // Active low

endmodule

`default_nettype wire

/* src/sd_spi_ctrl.sv */
// SD SPI-mode controller top; host strobes have no back-pressure and go unseen while busy
`timescale 1ns/1ps
`default_nettype none

module sd_spi_ctrl #(
  parameter int BLOCK_LEN = sd_spi_pkg::BLOCK_LEN_DEFAULT
) (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 cmd_read,
  input  logic                 cmd_write,
  input  sd_spi_pkg::sd_addr_t block_addr,
  input  sd_spi_pkg::sd_byte_t wr_data,
  output logic                 wr_data_pop,
  output sd_spi_pkg::sd_byte_t rd_data,
  output logic                 rd_data_valid,
  output logic                 busy,
  output logic                 error,
  output logic                 card_cs,
  output logic                 spi_start,
  output sd_spi_pkg::sd_byte_t spi_tx_data,
  input  logic                 spi_done,
  input  sd_spi_pkg::sd_byte_t spi_rx_data
);

  localparam int CNT_W = $clog2(BLOCK_LEN + 1);

  logic                  op_start;
  sd_spi_pkg::xfer_op_t  op_kind;
  logic [CNT_W-1:0]      op_count;
  sd_spi_pkg::sd_frame_t op_frame;
  logic                  op_done;
  sd_spi_pkg::sd_byte_t  op_resp;

  sd_card_seq #(.BLOCK_LEN(BLOCK_LEN)) u_sd_card_seq (
    .clk_i(clk_i), .rst_i(rst_i), .cmd_read(cmd_read), .cmd_write(cmd_write),
    .block_addr(block_addr), .busy(busy), .error(error), .card_cs(card_cs),
    .op_start(op_start), .op_kind(op_kind), .op_count(op_count), .op_frame(op_frame),
    .op_done(op_done), .op_resp(op_resp)
  );

  sd_xfer_engine #(.BLOCK_LEN(BLOCK_LEN)) u_sd_xfer_engine (
    .clk_i(clk_i), .rst_i(rst_i), .op_start(op_start), .op_kind(op_kind),
    .op_count(op_count), .op_frame(op_frame), .op_done(op_done), .op_resp(op_resp),
    .spi_start(spi_start), .spi_tx_data(spi_tx_data), .spi_done(spi_done),
    .spi_rx_data(spi_rx_data), .wr_data(wr_data), .wr_data_pop(wr_data_pop),
    .rd_data(rd_data), .rd_data_valid(rd_data_valid)
  );

endmodule

`default_nettype wire

/* test/tb_sd_spi_ctrl.sv */
// Testbench with a behavioral SD card on the SPI port; BLOCK_LEN 16, run stops at first failure
`timescale 1ns/1ps
`default_nettype none

module tb_sd_spi_ctrl;

  localparam int BLOCK_LEN = 16;
  localparam int INIT_BYTES = sd_spi_pkg::INIT_FILL_BYTES + 5 * 9; // Five frames with R1 gaps
  localparam int TIMEOUT_CYCLES = (INIT_BYTES + 4 * (BLOCK_LEN + 20)) * 8 + 200;

  logic        clk_i;
  logic        rst_i;
  logic        cmd_read;
  logic        cmd_write;
  logic [31:0] block_addr;
  logic [7:0]  wr_data;
  logic        wr_data_pop;
  logic [7:0]  rd_data;
  logic        rd_data_valid;
  logic        busy;
  logic        error;
  logic        card_cs;
  logic        spi_start;
  logic [7:0]  spi_tx_data;
  logic        spi_done;
  logic [7:0]  spi_rx_data;

  logic [7:0]  card_mem [int]; // Card storage keyed by block and offset
  logic [7:0]  reply_q [$];    // Bytes the card shifts out next
  logic [7:0]  frame_buf [6];
  logic [7:0]  pending_rx;
  logic [7:0]  last_cmd = 8'h00;
  logic [31:0] last_arg = '0;
  logic [31:0] cmd16_arg = '0;
  logic [31:0] wr_addr = '0;
  logic [31:0] rd_addr = '0;
  logic [31:0] rng = 32'h3338;
  int          frame_pos = 0;
  int          wr_phase = 0;    // 1 waits for start token, 2 takes data and CRC
  int          wr_pos = 0;
  int          wait_cnt = 0;
  int          cycle_cnt = 0;
  int          cs_high_fill = 0;
  int          cmd0_cnt = 0;
  int          cmd1_cnt = 0;
  int          token_cnt = 0;
  int          start_cnt = 0;
  int          pop_cnt = 0;
  int          rd_cnt = 0;
  bit          reject_rd = 1'b0;
  string       test_name = "reset";

  sd_spi_ctrl #(.BLOCK_LEN(BLOCK_LEN)) u_sd_spi_ctrl (.*);

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  // Write pattern, distinct per block address and offset
  function automatic logic [7:0] expected_byte(input logic [31:0] addr, input int idx);
    logic [31:0] x;
    x = xorshift32(xorshift32(32'h3338 ^ (addr << 12) ^ idx));
    return x[15:8];
  endfunction

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Done: errors found");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      fail_run($sformatf("MISMATCH %s: %s expected 0x%0h actual 0x%0h",
                         test_name, what, exp, act));
    end
  endtask

  // Card reaction to a complete six-byte frame
  task automatic run_command();
    logic [7:0] r1;
    r1       = 8'h00;
    last_cmd = frame_buf[0];
    last_arg = {frame_buf[1], frame_buf[2], frame_buf[3], frame_buf[4]};
    case (last_cmd)
      8'h40: begin
        cmd0_cnt++;
        r1 = 8'h01;
      end
      8'h41: begin
        cmd1_cnt++;
        r1 = (cmd1_cnt <= 2) ? 8'h01 : 8'h00; // Ready on the third try
      end
      8'h50:   cmd16_arg = last_arg;
      8'h51:   r1 = reject_rd ? 8'h04 : 8'h00;
      8'h58:   wr_phase = 1;
      default: r1 = 8'h04; // Illegal command
    endcase
    reply_q.push_back(8'hFF);
    reply_q.push_back(8'hFF);
    reply_q.push_back(r1);
    if ((last_cmd == 8'h51) && !reject_rd) begin
      repeat (3) reply_q.push_back(8'hFF); // Access delay before the token
      reply_q.push_back(8'hFE);
      for (int i = 0; i < BLOCK_LEN; i++) begin
        reply_q.push_back(card_mem[int'(last_arg) * BLOCK_LEN + i]);
      end
      repeat (2) reply_q.push_back(8'h00); // CRC
    end
  endtask

  task automatic card_exchange(input logic [7:0] tx, input logic cs_n, output logic [7:0] rx);
    rx = 8'hFF;
    if (reply_q.size() != 0) begin
      rx = reply_q.pop_front();
    end
    if (cs_n) begin
      if ((tx == 8'hFF) && (cmd0_cnt == 0)) begin
        cs_high_fill++;
      end
    end else if (wr_phase == 1) begin
      if (tx == 8'hFE) begin
        wr_phase = 2;
        wr_pos   = 0;
        token_cnt++;
      end
    end else if (wr_phase == 2) begin
      if (wr_pos < BLOCK_LEN) begin
        card_mem[int'(last_arg) * BLOCK_LEN + wr_pos] = tx;
      end
      wr_pos++;
      if (wr_pos == BLOCK_LEN + 2) begin
        wr_phase = 0;
        reply_q.push_back(8'hE5); // Data accepted
      end
    end else if ((frame_pos != 0) || (tx[7:6] == 2'b01)) begin
      frame_buf[frame_pos] = tx;
      frame_pos++;
      if (frame_pos == 6) begin
        frame_pos = 0;
        run_command();
      end
    end
  endtask

  task automatic issue_cmd(input logic rd, input logic [31:0] addr);
    cmd_read   <= rd;
    cmd_write  <= !rd;
    block_addr <= addr;
    @(posedge clk_i);
    cmd_read  <= 1'b0;
    cmd_write <= 1'b0;
    @(posedge clk_i);
    check_value("busy after strobe", 1, busy);
  endtask

  task automatic write_block(input logic [31:0] addr);
    int tokens;
    test_name = $sformatf("write 0x%0h", addr);
    tokens    = token_cnt;
    wr_addr   = addr;
    pop_cnt   = 0;
    wr_data  <= expected_byte(addr, 0);
    issue_cmd(1'b0, addr);
    while (busy) @(posedge clk_i);
    check_value("last command", 8'h58, last_cmd);
    check_value("block address", addr, last_arg);
    check_value("write tokens", tokens + 1, token_cnt);
    check_value("wr_data_pop count", BLOCK_LEN, pop_cnt);
    for (int i = 0; i < BLOCK_LEN; i++) begin
      check_value($sformatf("stored byte %0d", i), expected_byte(addr, i),
                  card_mem[int'(addr) * BLOCK_LEN + i]);
    end
    check_value("error", 0, error);
  endtask

  task automatic read_block(input logic [31:0] addr);
    test_name = $sformatf("read 0x%0h", addr);
    rd_addr   = addr;
    rd_cnt    = 0;
    issue_cmd(1'b1, addr);
    while (busy) @(posedge clk_i);
    check_value("last command", 8'h51, last_cmd);
    check_value("block address", addr, last_arg);
    check_value("rd_data_valid count", BLOCK_LEN, rd_cnt);
    check_value("error", 0, error);
  endtask

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // SPI engine with card model, 1 to 4 cycles per byte
  always @(posedge clk_i) begin
    spi_done <= 1'b0;
    if (spi_start) begin
      assert (wait_cnt == 0) else fail_run("spi_start while a byte exchange is outstanding");
      card_exchange(spi_tx_data, card_cs, pending_rx);
      rng      = xorshift32(rng);
      wait_cnt = int'(rng[1:0]) + 1;
      start_cnt++;
    end else if (wait_cnt != 0) begin
      wait_cnt--;
      if (wait_cnt == 0) begin
        spi_done    <= 1'b1;
        spi_rx_data <= pending_rx;
      end
    end
  end

  always @(posedge clk_i) begin
    if (wr_data_pop) begin
      pop_cnt++;
      wr_data <= expected_byte(wr_addr, pop_cnt); // Byte for the following pop
    end
  end

  always @(posedge clk_i) begin
    if (rd_data_valid) begin
      check_value($sformatf("rd_data byte %0d", rd_cnt), expected_byte(rd_addr, rd_cnt), rd_data);
      rd_cnt++;
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt++;
    assert (cycle_cnt < TIMEOUT_CYCLES) else begin
      fail_run($sformatf("Timeout after %0d cycles", cycle_cnt));
    end
  end

  initial begin
    int starts;
    rst_i       = 1'b1;
    cmd_read    = 1'b0;
    cmd_write   = 1'b0;
    block_addr  = '0;
    wr_data     = 8'hFF;
    spi_done    = 1'b0;
    spi_rx_data = 8'hFF;
    repeat (16) @(posedge clk_i);
    check_value("outputs in reset", 6'b000011,
                {spi_start, wr_data_pop, rd_data_valid, error, busy, card_cs});
    rst_i <= 1'b0;
    test_name = "init";
    while (busy) @(posedge clk_i);
    assert (cs_high_fill >= sd_spi_pkg::INIT_FILL_BYTES) else begin
      fail_run($sformatf("Only %0d fill bytes with card_cs high before CMD0", cs_high_fill));
    end
    check_value("CMD0 count", 1, cmd0_cnt);
    check_value("CMD1 count", 3, cmd1_cnt);
    check_value("CMD16 argument", BLOCK_LEN, cmd16_arg);
    check_value("error", 0, error);
    write_block(32'h5);
    read_block(32'h5);
    write_block(32'h11);
    write_block(32'h3);
    read_block(32'h3); // Reverse order
    read_block(32'h11);
    test_name = "rejected read";
    reject_rd = 1'b1;
    rd_cnt    = 0;
    issue_cmd(1'b1, 32'h7);
    while (!error) @(posedge clk_i);
    check_value("last command", 8'h51, last_cmd);
    check_value("card_cs", 1, card_cs);
    check_value("busy", 1, busy);
    starts = start_cnt;
    issue_cmd(1'b0, 32'h5);
    repeat (40) @(posedge clk_i);
    check_value("spi_start count", starts, start_cnt);
    check_value("rd_data_valid count", 0, rd_cnt);
    $display("Done: no errors");
    $finish;
  end

endmodule

`default_nettype wire

/* sd_spi_ctrl.f */
src/sd_spi_pkg.sv
src/sd_cmd_shifter.sv
src/sd_xfer_engine.sv
src/sd_card_seq.sv
src/sd_spi_ctrl.sv
test/tb_sd_spi_ctrl.sv

/* Bender.yml */
package:
  name: sd_spi_ctrl

sources:
  - src/sd_spi_pkg.sv
  - src/sd_cmd_shifter.sv
  - src/sd_xfer_engine.sv
  - src/sd_card_seq.sv
  - src/sd_spi_ctrl.sv
  - target: test
    files:
      - test/tb_sd_spi_ctrl.sv
